/* include/cache_consts.svh */
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// pipeline word and address
`define CACHE_XLEN      64
`define CACHE_ADDR_W    32

// address split: tag | index | byte offset
`define CACHE_TAG_W     21
`define CACHE_INDEX_W   6
`define CACHE_OFFSET_W  5

// sets per way
`define CACHE_SETS      64

// refill geometry, one line is four pipeline words
`define CACHE_BEATS     4
`define CACHE_LINE_W    256

`endif

/* hw/cacheBusPkg.sv */
`default_nettype none

`include "cache_consts.svh"

package cacheBusPkg;

  // load request from the pipeline
  typedef struct packed {
    logic [`CACHE_ADDR_W-1:0] addr;
  } cpuReq_t;

  // word returned with dataOk
  typedef struct packed {
    logic [`CACHE_XLEN-1:0] data;
  } cpuResp_t;

  // line request, low offset bits always zero
  typedef struct packed {
    logic [`CACHE_ADDR_W-1:0] addr;
  } memReq_t;

  // one refill beat, last marks the fourth
  typedef struct packed {
    logic [`CACHE_XLEN-1:0] data;
    logic                   last;
  } memBeat_t;

endpackage

`default_nettype wire

/* hw/cacheArrayPkg.sv */
`default_nettype none

`include "cache_consts.svh"

package cacheArrayPkg;

  typedef struct packed {
    logic [`CACHE_TAG_W-1:0]    tag;
    logic [`CACHE_INDEX_W-1:0]  index;
    logic [`CACHE_OFFSET_W-1:0] offset;
  } addrFields_t;

  typedef struct packed {
    logic                    valid;
    logic [`CACHE_TAG_W-1:0] tag;
  } tagEntry_t;

  // word 0 sits in the low bits, matching the lowest address
  typedef logic [`CACHE_BEATS-1:0][`CACHE_XLEN-1:0] lineData_t;

  typedef enum logic [2:0] {
    idle,
    compare,
    miss,
    refill,
    replay
  } ctrlState_e;

endpackage

`default_nettype wire

/* hw/cacheCtrlFsm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cacheCtrlFsm (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        valid_i,
  input  cacheBusPkg::cpuReq_t        req_i,
  input  logic                        hit_i,
  input  logic                        lastBeat_i,
  output logic                        addrOk_o,
  output logic                        rdEn_o,
  output logic [`CACHE_INDEX_W-1:0]   rdIdx_o,
  output cacheArrayPkg::addrFields_t  fields_o,
  output logic                        memReqValid_o,
  output cacheBusPkg::memReq_t        memReq_o,
  output logic                        refillDone_o,
  output logic                        dataOk_o
);
  import cacheBusPkg::*;
  import cacheArrayPkg::*;

  ctrlState_e  state;
  ctrlState_e  nextState;
  addrFields_t reqFields;
  logic        taken;

  assign reqFields = addrFields_t'(req_i.addr);

  // a hit in compare frees the slot for the next request
  assign addrOk_o = (state == idle) || ((state == compare) && hit_i);
  assign taken    = valid_i && addrOk_o;

  assign memReqValid_o = (state == miss);
  assign memReq_o.addr = {fields_o.tag, fields_o.index, {`CACHE_OFFSET_W{1'b0}}};

  // replay reads only once the line has been written
  assign rdEn_o  = taken || ((state == replay) && !refillDone_o);
  assign rdIdx_o = (state == replay) ? fields_o.index : reqFields.index;

  always_comb begin
    nextState = state;
    case (state)
      idle: begin
        if (taken) begin
          nextState = compare;
        end
      end
      compare: begin
        if (!hit_i) begin
          nextState = miss;
        end else if (!taken) begin
          nextState = idle;
        end
      end
      miss: begin
        nextState = refill;
      end
      refill: begin
        if (lastBeat_i) begin
          nextState = replay;
        end
      end
      replay: begin
        if (!refillDone_o) begin
          nextState = compare;
        end
      end
      default: begin
        nextState = idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= idle;
      refillDone_o <= 1'b0;
      dataOk_o     <= 1'b0;
    end else begin
      state        <= nextState;
      // write cycle follows the last beat
      refillDone_o <= (state == refill) && lastBeat_i;
      dataOk_o     <= (state == compare) && hit_i;
    end
  end

  always_ff @(posedge clk) begin
    if (taken) begin
      fields_o <= reqFields;
    end
  end

endmodule

`default_nettype wire

/* hw/refillBeatCounter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module refillBeatCounter (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             start_i,
  input  logic                             beatValid_i,
  output logic [$clog2(`CACHE_BEATS)-1:0]  beatIdx_o
);

  // beats come in address order, so the count is the word slot
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatIdx_o <= '0;
    end else if (start_i) begin
      beatIdx_o <= '0;
    end else if (beatValid_i) begin
      // wraps to zero after the last beat
      beatIdx_o <= beatIdx_o + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hw/cacheWayArray.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cacheWayArray #(
  parameter type entry_t      = logic,
  parameter bit  clearOnReset = 1'b0
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       rdEn_i,
  input  logic [`CACHE_INDEX_W-1:0]  rdIdx_i,
  input  logic                       wrEn_i,
  input  logic [`CACHE_INDEX_W-1:0]  wrIdx_i,
  input  entry_t                     wrData_i,
  output entry_t                     rdData_o
);

  entry_t mem [`CACHE_SETS];

  // registered read port
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdData_o <= '0;
    end else if (rdEn_i) begin
      rdData_o <= mem[rdIdx_i];
    end
  end

  generate
    if (clearOnReset) begin : gClear
      // tag store, reset drops every valid bit
      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          for (int i = 0; i < `CACHE_SETS; i++) begin
            mem[i] <= '0;
          end
        end else if (wrEn_i) begin
          mem[wrIdx_i] <= wrData_i;
        end
      end
    end else begin : gPlain
      always_ff @(posedge clk) begin
        if (wrEn_i) begin
          mem[wrIdx_i] <= wrData_i;
        end
      end
    end
  endgenerate

endmodule

`default_nettype wire

/* hw/cacheHitSelect.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cacheHitSelect (
  input  logic                        clk,
  input  cacheArrayPkg::tagEntry_t    tagWay0_i,
  input  cacheArrayPkg::tagEntry_t    tagWay1_i,
  input  cacheArrayPkg::lineData_t    lineWay0_i,
  input  cacheArrayPkg::lineData_t    lineWay1_i,
  input  cacheArrayPkg::addrFields_t  fields_i,
  output logic                        hit_o,
  output logic                        hitWay_o,
  output logic [`CACHE_XLEN-1:0]      word_o
);
  import cacheArrayPkg::*;

  // word select bits sit just above the byte-in-word bits
  localparam int wordSelLsb = $clog2(`CACHE_XLEN / 8);
  localparam int wordSelW   = $clog2(`CACHE_BEATS);

  logic                         hitWay0;
  logic                         hitWay1;
  logic [wordSelW-1:0]          wordSel;
  lineData_t                    hitLine;
  logic [`CACHE_XLEN-1:0]       hitWord;

  assign hitWay0 = tagWay0_i.valid && (tagWay0_i.tag == fields_i.tag);
  assign hitWay1 = tagWay1_i.valid && (tagWay1_i.tag == fields_i.tag);

  assign hit_o    = hitWay0 || hitWay1;
  // a line never sits in both ways, so way 1 alone decides
  assign hitWay_o = hitWay1;

  assign wordSel = fields_i.offset[wordSelLsb +: wordSelW];
  assign hitLine = hitWay_o ? lineWay1_i : lineWay0_i;
  assign hitWord = hitLine[wordSel];

  // response word, held for the dataOk cycle
  always_ff @(posedge clk) begin
    if (hit_o) begin
      word_o <= hitWord;
    end
  end

endmodule

`default_nettype wire

/* hw/cacheRefillUnit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cacheRefillUnit (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             beatValid_i,
  input  cacheBusPkg::memBeat_t            beat_i,
  input  logic [$clog2(`CACHE_BEATS)-1:0]  beatIdx_i,
  input  logic                             refillDone_i,
  input  cacheArrayPkg::addrFields_t       fields_i,
  output cacheArrayPkg::tagEntry_t         tagWr_o,
  output cacheArrayPkg::lineData_t         lineWr_o,
  output logic                             wrWay0_o,
  output logic                             wrWay1_o
);
  import cacheBusPkg::*;
  import cacheArrayPkg::*;

  // one round-robin bit per set, 0 means way 0 goes next
  logic [`CACHE_SETS-1:0] victimBits;
  logic                   victimWay;

  assign victimWay = victimBits[fields_i.index];

  // line assembly, each beat lands in its own word slot
  always_ff @(posedge clk) begin
    if (beatValid_i) begin
      lineWr_o[beatIdx_i] <= beat_i.data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      victimBits <= '0;
    end else if (refillDone_i) begin
      victimBits[fields_i.index] <= ~victimWay;
    end
  end

  assign tagWr_o.valid = 1'b1;
  assign tagWr_o.tag   = fields_i.tag;

  // tag and data of the victim way are written together
  assign wrWay0_o = refillDone_i && !victimWay;
  assign wrWay1_o = refillDone_i && victimWay;

endmodule

`default_nettype wire

/* hw/cacheTop.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cacheTop (
  input  logic                   clk,
  input  logic                   rst_n,
  // pipeline side
  input  logic                   valid_i,
  input  cacheBusPkg::cpuReq_t   req_i,
  output logic                   addrOk_o,
  output logic                   dataOk_o,
  output cacheBusPkg::cpuResp_t  resp_o,
  // memory side
  output logic                   memReqValid_o,
  output cacheBusPkg::memReq_t   memReq_o,
  input  logic                   beatValid_i,
  input  cacheBusPkg::memBeat_t  beat_i
);
  import cacheArrayPkg::*;

  addrFields_t                       fields;
  logic                              rdEn;
  logic [`CACHE_INDEX_W-1:0]         rdIdx;
  logic                              hit;
  logic                              refillDone;
  logic [$clog2(`CACHE_BEATS)-1:0]   beatIdx;

  tagEntry_t                         tagRd0;
  tagEntry_t                         tagRd1;
  lineData_t                         lineRd0;
  lineData_t                         lineRd1;

  tagEntry_t                         tagWr;
  lineData_t                         lineWr;
  logic                              wrWay0;
  logic                              wrWay1;

  cacheCtrlFsm u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .valid_i       (valid_i),
    .req_i         (req_i),
    .hit_i         (hit),
    .lastBeat_i    (beatValid_i & beat_i.last),
    .addrOk_o      (addrOk_o),
    .rdEn_o        (rdEn),
    .rdIdx_o       (rdIdx),
    .fields_o      (fields),
    .memReqValid_o (memReqValid_o),
    .memReq_o      (memReq_o),
    .refillDone_o  (refillDone),
    .dataOk_o      (dataOk_o)
  );

  refillBeatCounter u_beatCnt (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (memReqValid_o),
    .beatValid_i (beatValid_i),
    .beatIdx_o   (beatIdx)
  );

  // way 0 storage
  cacheWayArray #(.entry_t(tagEntry_t), .clearOnReset(1'b1)) u_tagWay0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .rdEn_i   (rdEn),
    .rdIdx_i  (rdIdx),
    .wrEn_i   (wrWay0),
    .wrIdx_i  (fields.index),
    .wrData_i (tagWr),
    .rdData_o (tagRd0)
  );

  cacheWayArray #(.entry_t(lineData_t), .clearOnReset(1'b0)) u_dataWay0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .rdEn_i   (rdEn),
    .rdIdx_i  (rdIdx),
    .wrEn_i   (wrWay0),
    .wrIdx_i  (fields.index),
    .wrData_i (lineWr),
    .rdData_o (lineRd0)
  );

  // way 1 storage
  cacheWayArray #(.entry_t(tagEntry_t), .clearOnReset(1'b1)) u_tagWay1 (
    .clk      (clk),
    .rst_n    (rst_n),
    .rdEn_i   (rdEn),
    .rdIdx_i  (rdIdx),
    .wrEn_i   (wrWay1),
    .wrIdx_i  (fields.index),
    .wrData_i (tagWr),
    .rdData_o (tagRd1)
  );

  cacheWayArray #(.entry_t(lineData_t), .clearOnReset(1'b0)) u_dataWay1 (
    .clk      (clk),
    .rst_n    (rst_n),
    .rdEn_i   (rdEn),
    .rdIdx_i  (rdIdx),
    .wrEn_i   (wrWay1),
    .wrIdx_i  (fields.index),
    .wrData_i (lineWr),
    .rdData_o (lineRd1)
  );

  cacheHitSelect u_hitSel (
    .clk        (clk),
    .tagWay0_i  (tagRd0),
    .tagWay1_i  (tagRd1),
    .lineWay0_i (lineRd0),
    .lineWay1_i (lineRd1),
    .fields_i   (fields),
    .hit_o      (hit),
    .hitWay_o   (),
    .word_o     (resp_o.data)
  );

  cacheRefillUnit u_refill (
    .clk          (clk),
    .rst_n        (rst_n),
    .beatValid_i  (beatValid_i),
    .beat_i       (beat_i),
    .beatIdx_i    (beatIdx),
    .refillDone_i (refillDone),
    .fields_i     (fields),
    .tagWr_o      (tagWr),
    .lineWr_o     (lineWr),
    .wrWay0_o     (wrWay0),
    .wrWay1_o     (wrWay1)
  );

endmodule

`default_nettype wire

/* sim/memBurstModel.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module memBurstModel #(
  parameter logic [31:0] seed = 32'h2343
) (
  input  logic                   clk,
  input  logic                   memReqValid_i,
  input  cacheBusPkg::memReq_t   memReq_i,
  output logic                   beatValid_o,
  output cacheBusPkg::memBeat_t  beat_o
);
  import cacheBusPkg::*;

  logic [31:0] gapState;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // beat content depends only on line address and beat number
  function automatic logic [`CACHE_XLEN-1:0] beatWord(input logic [`CACHE_ADDR_W-1:0] lineAddr,
                                                      input int beatNum);
    logic [31:0] lo;
    logic [31:0] hi;
    // seed low bits keep the input nonzero
    lo = xorshift32(lineAddr ^ seed ^ (beatNum << 3));
    hi = xorshift32(lo);
    return {hi, lo};
  endfunction

  // zero to three idle cycles before a beat
  function automatic int nextGap();
    gapState = xorshift32(gapState);
    return int'(gapState[1:0]);
  endfunction

  task automatic serveLine(input logic [`CACHE_ADDR_W-1:0] lineAddr);
    int gap;
    for (int b = 0; b < `CACHE_BEATS; b++) begin
      gap = nextGap();
      repeat (gap) begin
        @(posedge clk);
        #1;
        beatValid_o = 1'b0;
      end
      @(posedge clk);
      #1;
      beatValid_o = 1'b1;
      beat_o.data = beatWord(lineAddr, b);
      beat_o.last = (b == `CACHE_BEATS - 1);
    end
    @(posedge clk);
    #1;
    beatValid_o = 1'b0;
    beat_o.last = 1'b0;
  endtask

  initial begin
    gapState    = seed;
    beatValid_o = 1'b0;
    beat_o      = '0;
    forever begin
      // request pulse is looked at mid-cycle
      @(negedge clk);
      if (memReqValid_i) begin
        serveLine(memReq_i.addr);
      end
    end
  end

endmodule

`default_nettype wire

/* sim/tb_cacheTop.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module tb_cacheTop;
  import cacheBusPkg::*;

  localparam int          clkPeriod = 4;
  localparam int          numStim   = 24;
  localparam logic [31:0] rngSeed   = 32'h2343;
  localparam int          wordLsb   = 3;

  typedef struct packed {
    logic [`CACHE_ADDR_W-1:0] addr;
    logic                     expMiss;
  } stim_t;

  // one outstanding access in take order
  typedef struct packed {
    logic [`CACHE_ADDR_W-1:0] addr;
    logic                     miss;
    logic [`CACHE_XLEN-1:0]   word;
    logic [31:0]              takeEdge;
  } expect_t;

  logic     clk = 1'b0;
  logic     rst_n;
  logic     valid;
  cpuReq_t  req;
  logic     addrOk;
  logic     dataOk;
  cpuResp_t resp;
  logic     memReqValid;
  memReq_t  memReq;
  logic     beatValid;
  memBeat_t beat;

  // reference tags and round-robin bits
  logic                    refValid  [2][`CACHE_SETS];
  logic [`CACHE_TAG_W-1:0] refTag    [2][`CACHE_SETS];
  logic                    refVictim [`CACHE_SETS];

  expect_t     pending [$];
  int          edgeCnt    = 0;
  int          takenCount = 0;
  int          respCount  = 0;
  int          lineReqs   = 0;
  logic [31:0] lastTakeEdge;
  logic        lastWasHit;

  // set 5 cycles through tags 1, 2 and 3; other sets cover edges of the index
  stim_t stimTable [numStim] = '{
    {32'h0000_08A0, 1'b1}, {32'h0000_08A8, 1'b0}, {32'h0000_08B0, 1'b0},
    {32'h0000_08B8, 1'b0}, {32'h0000_10A8, 1'b1}, {32'h0000_08A0, 1'b0},
    {32'h0000_18B0, 1'b1}, {32'h0000_10B8, 1'b0}, {32'h0000_08A8, 1'b1},
    {32'h0000_18A0, 1'b0}, {32'h0000_10A0, 1'b1}, {32'h8765_4320, 1'b1},
    {32'h8765_4338, 1'b0}, {32'h8765_4330, 1'b0}, {32'h8765_4328, 1'b0},
    {32'h8765_4324, 1'b0}, {32'hFFFF_FFE0, 1'b1}, {32'hFFFF_FFF8, 1'b0},
    {32'h0000_0000, 1'b1}, {32'h0000_0018, 1'b0}, {32'h0000_18B8, 1'b1},
    {32'h0000_10B0, 1'b0}, {32'h0000_08B0, 1'b1}, {32'h8765_4330, 1'b0}
  };

  always #(clkPeriod / 2) clk = ~clk;

  always @(posedge clk) begin
    edgeCnt = edgeCnt + 1;
  end

  cacheTop u_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .valid_i       (valid),
    .req_i         (req),
    .addrOk_o      (addrOk),
    .dataOk_o      (dataOk),
    .resp_o        (resp),
    .memReqValid_o (memReqValid),
    .memReq_o      (memReq),
    .beatValid_i   (beatValid),
    .beat_i        (beat)
  );

  memBurstModel #(.seed(rngSeed)) u_mem (
    .clk           (clk),
    .memReqValid_i (memReqValid),
    .memReq_i      (memReq),
    .beatValid_o   (beatValid),
    .beat_o        (beat)
  );

  task automatic stopOnError();
    $display("TEST FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic expectEqual(input logic [63:0] got, input logic [63:0] exp, input string what);
    assert (got === exp) else begin
      $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
      stopOnError();
    end
  endtask

  task automatic expectTrue(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("[FAIL] %0t ns: %s", $time, what);
      stopOnError();
    end
  endtask

  function automatic logic [`CACHE_ADDR_W-1:0] lineAddrOf(input logic [`CACHE_ADDR_W-1:0] addr);
    return {addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W], {`CACHE_OFFSET_W{1'b0}}};
  endfunction

  task automatic clearRefModel();
    for (int s = 0; s < `CACHE_SETS; s++) begin
      refValid[0][s] = 1'b0;
      refValid[1][s] = 1'b0;
      refTag[0][s]   = '0;
      refTag[1][s]   = '0;
      refVictim[s]   = 1'b0;
    end
  endtask

  // look up and on a miss fill the victim way and flip its bit
  task automatic predictAccess(input logic [`CACHE_ADDR_W-1:0] addr, output logic miss);
    logic [`CACHE_TAG_W-1:0]   tag;
    logic [`CACHE_INDEX_W-1:0] idx;
    logic                      way;
    tag  = addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    idx  = addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
    miss = 1'b1;
    for (int w = 0; w < 2; w++) begin
      if (refValid[w][idx] && refTag[w][idx] == tag) begin
        miss = 1'b0;
      end
    end
    if (miss) begin
      way                = refVictim[idx];
      refValid[way][idx] = 1'b1;
      refTag[way][idx]   = tag;
      refVictim[idx]     = ~way;
    end
  endtask

  task automatic recordTake();
    expect_t e;
    logic    miss;
    predictAccess(req.addr, miss);
    expectTrue(miss === stimTable[takenCount].expMiss,
               "reference model disagrees with the stimulus table");
    e.addr     = req.addr;
    e.miss     = miss;
    e.word     = u_mem.beatWord(lineAddrOf(req.addr),
                                int'(req.addr[`CACHE_OFFSET_W-1:wordLsb]));
    e.takeEdge = edgeCnt + 1;
    // a hit frees the slot for the very next edge
    if (takenCount > 0 && lastWasHit) begin
      expectEqual(e.takeEdge, lastTakeEdge + 1, "take edge after a hit");
    end
    lastTakeEdge = e.takeEdge;
    lastWasHit   = !miss;
    takenCount   = takenCount + 1;
    pending.push_back(e);
  endtask

  task automatic matchLineReq();
    expect_t head;
    expectTrue(pending.size() > 0, "line request with no access outstanding");
    head = pending[0];
    expectTrue(head.miss, "line request for an access that should hit");
    expectEqual(memReq.addr, lineAddrOf(head.addr), "line request address");
    lineReqs = lineReqs + 1;
  endtask

  task automatic retireResponse();
    expect_t head;
    expectTrue(pending.size() > 0, "dataOk with no access outstanding");
    head = pending.pop_front();
    expectEqual(resp.data, head.word, "returned word");
    expectEqual(lineReqs, head.miss, "line requests for this access");
    if (!head.miss) begin
      expectEqual(edgeCnt + 1 - head.takeEdge, 2, "hit latency in cycles");
    end
    lineReqs  = 0;
    respCount = respCount + 1;
  endtask

  // outputs are looked at mid-cycle where they have settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (dataOk) begin
        retireResponse();
      end
      if (valid && addrOk) begin
        recordTake();
      end
      if (memReqValid) begin
        matchLineReq();
      end
    end
  end

  initial begin
    #((numStim * 40 + 3) * clkPeriod);
    $display("Watchdog expired with %0d of %0d responses received", respCount, numStim);
    $display("TEST FAIL");
    $fatal(1, "watchdog");
  end

  initial begin
    rst_n = 1'b0;
    valid = 1'b0;
    req   = '0;
    clearRefModel();
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    expectTrue(addrOk === 1'b1, "addrOk is not high after reset");
    expectTrue(dataOk === 1'b0, "dataOk is not low after reset");
    expectTrue(memReqValid === 1'b0, "memReqValid is not low after reset");
    @(posedge clk);
    #1;
    for (int i = 0; i < numStim; i++) begin
      valid    = 1'b1;
      req.addr = stimTable[i].addr;
      // hold the request until the cache takes it
      @(negedge clk);
      while (!addrOk) begin
        @(negedge clk);
      end
      @(posedge clk);
      #1;
    end
    valid = 1'b0;
    req   = '0;
    wait (respCount == numStim);
    repeat (4) @(negedge clk);
    expectTrue(addrOk === 1'b1, "addrOk is not high once all accesses are served");
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+include
hw/cacheBusPkg.sv
hw/cacheArrayPkg.sv
hw/cacheCtrlFsm.sv
hw/refillBeatCounter.sv
hw/cacheWayArray.sv
hw/cacheHitSelect.sv
hw/cacheRefillUnit.sv
hw/cacheTop.sv
sim/memBurstModel.sv
sim/tb_cacheTop.sv
